// ==== all.f ====
+incdir+verilog
verilog/decode_pkg.sv
verilog/instruction_decoder.sv
verilog/issue_control.sv
verilog/alu_operand_builder.sv
verilog/load_store_tracker.sv
verilog/div_reuse_tracker.sv
verilog/decode_issue.sv
verification/decode_issue_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module decode_issue_tb \
    -f all.f --Mdir obj_dir -o decode_issue_sim
./obj_dir/decode_issue_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass"
    exit 1
fi

// ==== verification/decode_issue_tb.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module decode_issue_tb;

    localparam int clk_period = 20;
    localparam int drive_delay = 2;
    localparam int num_instr = 3000;
    localparam int max_cycles_per_instr = 20;
    localparam int timeout_ns = num_instr * max_cycles_per_instr * clk_period + 2000;

    logic clk;
    logic rst;
    logic fb_valid;
    decode_pkg::fetch_packet_t fb;
    logic fb_pop;
    decode_pkg::rf_request_t rf_req;
    decode_pkg::rf_response_t rf_rsp;
    logic id_available;
    logic issue_hold;
    decode_pkg::unit_vec_t unit_ready;
    decode_pkg::unit_vec_t unit_issue;
    logic instruction_issued;
    logic illegal_instruction;
    decode_pkg::alu_inputs_t alu_inputs;
    decode_pkg::branch_inputs_t branch_inputs;
    decode_pkg::ls_inputs_t ls_inputs;
    decode_pkg::div_inputs_t div_inputs;

    // Scoreboard model
    logic [`NUM_REGS-1:0] pending;
    decode_pkg::instr_id_t pending_id [`NUM_REGS];

    // Reference tracking state
    logic [`NUM_REGS-1:0] was_load;
    logic [4:0] last_ls_rd;
    logic [4:0] prev_rs1;
    logic [4:0] prev_rs2;
    logic div_valid;

    // Reference decode of the current packet
    logic [4:0] m_opcode;
    logic [2:0] m_fn3;
    logic [4:0] m_rs1;
    logic [4:0] m_rs2;
    logic [4:0] m_rd;
    logic m_uses_rs1;
    logic m_uses_rs2;
    logic m_uses_rd;
    logic m_illegal;
    decode_pkg::unit_vec_t m_unit;

    logic holding;
    logic mid_reset_done;
    int errors;
    int checks;
    int done_count;

    decode_issue i_dut (
        .clk(clk),
        .rst(rst),
        .fb_valid(fb_valid),
        .fb(fb),
        .fb_pop(fb_pop),
        .rf_req(rf_req),
        .rf_rsp(rf_rsp),
        .id_available(id_available),
        .issue_hold(issue_hold),
        .unit_ready(unit_ready),
        .unit_issue(unit_issue),
        .instruction_issued(instruction_issued),
        .illegal_instruction(illegal_instruction),
        .alu_inputs(alu_inputs),
        .branch_inputs(branch_inputs),
        .ls_inputs(ls_inputs),
        .div_inputs(div_inputs)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    function automatic logic [4:0] pool_reg();
        // Small pool so that conflicts and reuse show up often
        return 5'($urandom_range(0, 6));
    endfunction

    function automatic logic [31:0] random_instruction();
        logic [31:0] instr;
        logic [4:0] opcode;
        int kind;
        instr = $urandom();
        kind = $urandom_range(0, 14);
        case (kind)
            0: opcode = decode_pkg::LUI_T;
            1: opcode = decode_pkg::AUIPC_T;
            2: opcode = decode_pkg::JAL_T;
            3: opcode = decode_pkg::JALR_T;
            4: opcode = decode_pkg::BRANCH_T;
            5, 6: opcode = decode_pkg::LOAD_T;
            7, 8: opcode = decode_pkg::STORE_T;
            9: opcode = decode_pkg::ARITH_IMM_T;
            10, 11, 12, 13: opcode = decode_pkg::ARITH_T;
            default: begin
                case ($urandom_range(0, 2))
                    0: opcode = decode_pkg::FENCE_T;
                    1: opcode = decode_pkg::SYSTEM_T;
                    default: opcode = decode_pkg::AMO_T;
                endcase
            end
        endcase
        instr[6:0] = {opcode, 2'b11};
        instr[11:7] = pool_reg();
        instr[19:15] = pool_reg();
        instr[24:20] = pool_reg();
        // 10 plain ALU, 11 and 12 divide, 13 multiply
        if (kind == 10)
            instr[25] = 1'b0;
        if (kind == 11 || kind == 12 || kind == 13) begin
            instr[25] = 1'b1;
            instr[14] = (kind != 13);
        end
        return instr;
    endfunction

    task automatic drive_cycle();
        decode_pkg::reg_addr_t rs1;
        decode_pkg::reg_addr_t rs2;
        // Fetch buffer keeps a waiting packet steady
        if (!holding) begin
            fb_valid = ($urandom_range(0, 9) < 7);
            fb.pc = $urandom();
            fb.instruction = random_instruction();
        end
        id_available = ($urandom_range(0, 9) < 8);
        issue_hold = ($urandom_range(0, 9) == 0);
        for (int u = 0; u < `NUM_UNITS; u++)
            unit_ready[u] = ($urandom_range(0, 3) != 0);
        rs1 = fb.instruction[19:15];
        rs2 = fb.instruction[24:20];
        rf_rsp.rs1_data = $urandom();
        rf_rsp.rs2_data = $urandom();
        rf_rsp.rs1_conflict = pending[rs1];
        rf_rsp.rs2_conflict = pending[rs2];
        rf_rsp.rs2_id = pending_id[rs2];
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        fb_valid = 1'b0;
        repeat (2) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        pending = '0;
        was_load = '0;
        div_valid = 1'b0;
        holding = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Reference model

    task automatic decode_model(input logic [31:0] instr);
        m_opcode = instr[6:2];
        m_fn3 = instr[14:12];
        m_rs1 = instr[19:15];
        m_rs2 = instr[24:20];
        m_rd = instr[11:7];
        m_uses_rs1 = 1'b0;
        m_uses_rs2 = 1'b0;
        m_uses_rd = 1'b0;
        m_illegal = 1'b0;
        m_unit = '0;
        case (m_opcode)
            decode_pkg::LUI_T, decode_pkg::AUIPC_T, decode_pkg::ARITH_IMM_T: begin
                m_uses_rs1 = (m_opcode == decode_pkg::ARITH_IMM_T);
                m_uses_rd = 1'b1;
                m_unit[`ALU_UNIT] = 1'b1;
            end
            decode_pkg::JAL_T, decode_pkg::JALR_T: begin
                m_uses_rs1 = (m_opcode == decode_pkg::JALR_T);
                m_uses_rd = 1'b1;
                m_unit[`BRANCH_UNIT] = 1'b1;
            end
            decode_pkg::BRANCH_T: begin
                m_uses_rs1 = 1'b1;
                m_uses_rs2 = 1'b1;
                m_unit[`BRANCH_UNIT] = 1'b1;
            end
            decode_pkg::LOAD_T, decode_pkg::STORE_T: begin
                m_uses_rs1 = 1'b1;
                m_uses_rs2 = (m_opcode == decode_pkg::STORE_T);
                m_uses_rd = (m_opcode == decode_pkg::LOAD_T);
                m_unit[`LS_UNIT] = 1'b1;
            end
            decode_pkg::ARITH_T: begin
                m_uses_rs1 = 1'b1;
                m_uses_rs2 = 1'b1;
                m_uses_rd = 1'b1;
                // Multiply encodings have no unit here
                if (!instr[25])
                    m_unit[`ALU_UNIT] = 1'b1;
                else if (instr[14])
                    m_unit[`DIV_UNIT] = 1'b1;
                else
                    m_illegal = 1'b1;
            end
            default: m_illegal = 1'b1;
        endcase
    endtask

    task automatic check_alu();
        logic [31:0] instr;
        logic [31:0] op1;
        logic [31:0] op2;
        logic upper;
        logic exp_sub;
        instr = fb.instruction;
        upper = (m_opcode == decode_pkg::LUI_T) || (m_opcode == decode_pkg::AUIPC_T);
        if (m_opcode == decode_pkg::LUI_T)
            op1 = '0;
        else if (m_opcode == decode_pkg::AUIPC_T)
            op1 = fb.pc;
        else
            op1 = rf_rsp.rs1_data;
        if (upper)
            op2 = {instr[31:12], 12'h000};
        else if (m_opcode == decode_pkg::ARITH_IMM_T)
            op2 = {{20{instr[31]}}, instr[31:20]};
        else
            op2 = rf_rsp.rs2_data;
        // Top bit is the sign, cleared for the unsigned variants
        check_value(128'(alu_inputs.in1), 128'({op1[31] & ~m_fn3[0], op1}), "alu in1");
        check_value(128'(alu_inputs.in2), 128'({op2[31] & ~m_fn3[0], op2}), "alu in2");
        exp_sub = !upper && ((m_fn3[2:1] == 2'b01)
                  || (m_opcode == decode_pkg::ARITH_T && m_fn3 == 3'b000 && instr[30]));
        check_value(128'(alu_inputs.subtract), 128'(exp_sub), "alu subtract");
        check_value(128'(alu_inputs.shifter_path), 128'(!upper && m_fn3[1:0] == 2'b01),
                    "alu shifter_path");
        check_value(128'(alu_inputs.slt_path), 128'(!upper && m_fn3[2:1] == 2'b01),
                    "alu slt_path");
        // Shift direction and fill, logic function from fn3
        check_value(128'(alu_inputs.lshift), 128'(!m_fn3[2]), "alu lshift");
        check_value(128'(alu_inputs.arith), 128'(op1[31] & instr[30]), "alu arith");
        check_value(128'(alu_inputs.logic_op), 128'(m_fn3[1:0]), "alu logic_op");
        if (!upper) begin
            check_value(128'(alu_inputs.shift_amount),
                        128'((m_opcode == decode_pkg::ARITH_T) ? rf_rsp.rs2_data[4:0] : m_rs2),
                        "alu shift_amount");
        end
    endtask

    task automatic check_branch();
        decode_pkg::branch_inputs_t expected_br;
        expected_br.rs1 = rf_rsp.rs1_data;
        expected_br.rs2 = rf_rsp.rs2_data;
        expected_br.pc = fb.pc;
        expected_br.fn3 = m_fn3;
        expected_br.use_signed = (m_fn3[2:1] != 2'b11);
        expected_br.jal = (m_opcode == decode_pkg::JAL_T);
        expected_br.jalr = (m_opcode == decode_pkg::JALR_T);
        check_value(128'(branch_inputs), 128'(expected_br), "branch_inputs");
    endtask

    task automatic check_ls(input logic fwd_ok);
        decode_pkg::ls_inputs_t expected_ls;
        logic [31:0] instr;
        instr = fb.instruction;
        expected_ls.rs1 = rf_rsp.rs1_data;
        expected_ls.rs2 = rf_rsp.rs2_data;
        expected_ls.offset = (m_opcode == decode_pkg::STORE_T) ?
            {instr[31:25], instr[11:7]} : instr[31:20];
        expected_ls.fn3 = m_fn3;
        expected_ls.load = (m_opcode == decode_pkg::LOAD_T);
        expected_ls.store = (m_opcode == decode_pkg::STORE_T);
        expected_ls.load_store_forward = rf_rsp.rs2_conflict && fwd_ok;
        expected_ls.store_forward_id = rf_rsp.rs2_id;
        check_value(128'(ls_inputs), 128'(expected_ls), "ls_inputs");
    endtask

    task automatic check_div();
        decode_pkg::div_inputs_t expected_div;
        expected_div.rs1 = rf_rsp.rs1_data;
        expected_div.rs2 = rf_rsp.rs2_data;
        expected_div.op = m_fn3[1:0];
        expected_div.reuse_result = div_valid && prev_rs1 == m_rs1 && prev_rs2 == m_rs2;
        check_value(128'(div_inputs), 128'(expected_div), "div_inputs");
    endtask

    task automatic check_cycle();
        decode_pkg::unit_vec_t exp_issue;
        logic fwd_ok;
        logic rs1_ok;
        logic rs2_ok;
        logic store_fwd;
        decode_model(fb.instruction);
        fwd_ok = was_load[m_rs2] && (last_ls_rd == m_rs2);
        rs1_ok = !(m_uses_rs1 && rf_rsp.rs1_conflict);
        rs2_ok = !(m_uses_rs2 && rf_rsp.rs2_conflict);
        store_fwd = (m_opcode == decode_pkg::STORE_T) && fwd_ok;
        exp_issue = '0;
        if (fb_valid && id_available && !issue_hold && !m_illegal
            && rs1_ok && (rs2_ok || store_fwd))
            exp_issue = m_unit & unit_ready;
        check_value(128'(unit_issue), 128'(exp_issue), "unit_issue");
        check_value(128'(fb_pop), 128'(|exp_issue), "fb_pop");
        check_value(128'(instruction_issued), 128'(|exp_issue), "instruction_issued");
        check_value(128'(illegal_instruction), 128'(fb_valid && m_illegal),
                    "illegal_instruction");
        check_value(128'(rf_req), 128'({m_rs1, m_rs2, m_rd}), "rf_req");
        if (exp_issue[`ALU_UNIT])
            check_alu();
        if (exp_issue[`BRANCH_UNIT])
            check_branch();
        if (exp_issue[`LS_UNIT])
            check_ls(fwd_ok);
        if (exp_issue[`DIV_UNIT])
            check_div();
    endtask

    // Follows the issues seen on the DUT outputs
    task automatic update_model();
        for (int r = 1; r < `NUM_REGS; r++)
            if (pending[r] && $urandom_range(0, 3) == 0)
                pending[r] = 1'b0;
        if (|unit_issue) begin
            was_load[m_rd] = unit_issue[`LS_UNIT] && (m_opcode == decode_pkg::LOAD_T);
            if (unit_issue[`LS_UNIT])
                last_ls_rd = m_rd;
            if (unit_issue[`DIV_UNIT]) begin
                prev_rs1 = m_rs1;
                prev_rs2 = m_rs2;
                div_valid = (m_rd != m_rs1) && (m_rd != m_rs2);
            end else if (m_uses_rd && (m_rd == prev_rs1 || m_rd == prev_rs2)) begin
                div_valid = 1'b0;
            end
            if (m_uses_rd && m_rd != 5'd0) begin
                pending[m_rd] = 1'b1;
                pending_id[m_rd] = 3'($urandom_range(0, 7));
            end
        end
        // Illegal packets are dropped by the front end
        if (fb_valid && (fb_pop || m_illegal))
            done_count++;
        holding = fb_valid && !fb_pop && !m_illegal;
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        void'($urandom(61213));
        errors = 0;
        checks = 0;
        done_count = 0;
        mid_reset_done = 1'b0;
        last_ls_rd = '0;
        prev_rs1 = '0;
        prev_rs2 = '0;
        for (int r = 0; r < `NUM_REGS; r++)
            pending_id[r] = '0;
        rst = 1'b1;
        fb_valid = 1'b0;
        fb = '0;
        rf_rsp = '0;
        id_available = 1'b0;
        issue_hold = 1'b0;
        unit_ready = '0;
        apply_reset();
        while (done_count < num_instr) begin
            // Second reset halfway through
            if (done_count >= num_instr / 2 && !mid_reset_done) begin
                mid_reset_done = 1'b1;
                apply_reset();
            end
            drive_cycle();
            #(clk_period - drive_delay - 3);
            check_cycle();
            update_model();
            @(posedge clk);
            #(drive_delay);
        end
        $display("Summary: %0d instructions, %0d checks, %0d errors", done_count, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== verilog/alu_operand_builder.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module alu_operand_builder (
    input decode_pkg::fetch_packet_t fb,
    input decode_pkg::decoded_t decoded,
    input decode_pkg::rf_response_t rf_rsp,
    output decode_pkg::alu_inputs_t alu_inputs,
    output decode_pkg::branch_inputs_t branch_inputs
);

    decode_pkg::data_t alu_rs1_data;
    decode_pkg::data_t alu_rs2_data;
    logic not_arith_op;

    //////////////////////////////////////////////////
    // ALU operands
    always_comb begin
        case (decoded.alu_rs1_sel)
            decode_pkg::ALU_RS1_ZERO: alu_rs1_data = '0;
            decode_pkg::ALU_RS1_PC: alu_rs1_data = fb.pc;
            default: alu_rs1_data = rf_rsp.rs1_data;
        endcase

        case (decoded.alu_rs2_sel)
            decode_pkg::ALU_RS2_UPPER_IMM:
                alu_rs2_data = {fb.instruction[31:12], 12'b0};
            decode_pkg::ALU_RS2_ARITH_IMM:
                alu_rs2_data = {{(`XLEN-12){fb.instruction[31]}}, fb.instruction[31:20]};
            // Return address offset
            decode_pkg::ALU_RS2_LINK4:
                alu_rs2_data = decode_pkg::data_t'(4);
            default:
                alu_rs2_data = rf_rsp.rs2_data;
        endcase
    end

    // LUI, AUIPC, JAL and JALR all have opcode bit 2 set
    assign not_arith_op = decoded.opcode[0];

    // fn3[0] set means SLTU, compare as unsigned
    assign alu_inputs.in1 = {alu_rs1_data[`XLEN-1] & ~decoded.fn3[0], alu_rs1_data};
    assign alu_inputs.in2 = {alu_rs2_data[`XLEN-1] & ~decoded.fn3[0], alu_rs2_data};

    // Register shift amount for ARITH, immediate field otherwise
    assign alu_inputs.shift_amount = decoded.opcode[3] ? rf_rsp.rs2_data[4:0]
                                                        : decoded.rs2_addr;
    assign alu_inputs.subtract = decoded.alu_sub;
    assign alu_inputs.arith = alu_rs1_data[`XLEN-1] & fb.instruction[30];
    assign alu_inputs.lshift = ~decoded.fn3[2];
    assign alu_inputs.shifter_path = ~not_arith_op & (decoded.fn3 inside {3'b001, 3'b101});
    assign alu_inputs.slt_path = ~not_arith_op & (decoded.fn3 inside {3'b010, 3'b011});
    assign alu_inputs.logic_op = decoded.fn3[1:0];

    //////////////////////////////////////////////////
    // Branch operands
    assign branch_inputs.rs1 = rf_rsp.rs1_data;
    assign branch_inputs.rs2 = rf_rsp.rs2_data;
    assign branch_inputs.pc = fb.pc;
    assign branch_inputs.fn3 = decoded.fn3;
    // BLTU and BGEU
    assign branch_inputs.use_signed = !(decoded.fn3 inside {3'b110, 3'b111});
    assign branch_inputs.jal = decoded.opcode[1];
    assign branch_inputs.jalr = ~decoded.opcode[1] & decoded.opcode[0];

endmodule

// ==== verilog/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

//////////////////////////////////////////////////
// Datapath sizes

// Register value width
`define XLEN 32

// Architectural integer registers
`define NUM_REGS 32

//////////////////////////////////////////////////
// Execution units

`define NUM_UNITS 4

// Bit positions in one-bit-per-unit vectors
`define ALU_UNIT 0
`define BRANCH_UNIT 1
`define LS_UNIT 2
`define DIV_UNIT 3

`endif

// ==== verilog/decode_issue.sv ====
`timescale 1ns/10ps

module decode_issue (
    input logic clk,
    input logic rst,
    input logic fb_valid,
    input decode_pkg::fetch_packet_t fb,
    output logic fb_pop,
    output decode_pkg::rf_request_t rf_req,
    input decode_pkg::rf_response_t rf_rsp,
    input logic id_available,
    input logic issue_hold,
    input decode_pkg::unit_vec_t unit_ready,
    output decode_pkg::unit_vec_t unit_issue,
    output logic instruction_issued,
    output logic illegal_instruction,
    output decode_pkg::alu_inputs_t alu_inputs,
    output decode_pkg::branch_inputs_t branch_inputs,
    output decode_pkg::ls_inputs_t ls_inputs,
    output decode_pkg::div_inputs_t div_inputs
);

    decode_pkg::decoded_t decoded;
    logic forward_ok;

    instruction_decoder i_decoder (
        .fb(fb),
        .decoded(decoded)
    );

    // Scoreboard lookup
    assign rf_req.rs1_addr = decoded.rs1_addr;
    assign rf_req.rs2_addr = decoded.rs2_addr;
    assign rf_req.rd_addr = decoded.rd_addr;

    issue_control i_issue_control (
        .clk(clk),
        .rst(rst),
        .fb_valid(fb_valid),
        .decoded(decoded),
        .rf_rsp(rf_rsp),
        .forward_ok(forward_ok),
        .id_available(id_available),
        .issue_hold(issue_hold),
        .unit_ready(unit_ready),
        .unit_issue(unit_issue),
        .instruction_issued(instruction_issued),
        .fb_pop(fb_pop),
        .illegal_instruction(illegal_instruction)
    );

    alu_operand_builder i_alu_operands (
        .fb(fb),
        .decoded(decoded),
        .rf_rsp(rf_rsp),
        .alu_inputs(alu_inputs),
        .branch_inputs(branch_inputs)
    );

    load_store_tracker i_ls_tracker (
        .clk(clk),
        .rst(rst),
        .fb(fb),
        .decoded(decoded),
        .rf_rsp(rf_rsp),
        .issue(unit_issue),
        .instruction_issued(instruction_issued),
        .forward_ok(forward_ok),
        .ls_inputs(ls_inputs)
    );

    div_reuse_tracker i_div_tracker (
        .clk(clk),
        .rst(rst),
        .decoded(decoded),
        .rf_rsp(rf_rsp),
        .issue(unit_issue),
        .instruction_issued(instruction_issued),
        .div_inputs(div_inputs)
    );

endmodule

// ==== verilog/decode_pkg.sv ====
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_addr_t;
    typedef logic [2:0] instr_id_t;
    typedef logic [2:0] fn3_t;
    typedef logic [`NUM_UNITS-1:0] unit_vec_t;

    //////////////////////////////////////////////////
    // Opcodes, instruction bits [6:2]
    typedef enum logic [4:0] {
        LOAD_T      = 5'b00000,
        FENCE_T     = 5'b00011,
        ARITH_IMM_T = 5'b00100,
        AUIPC_T     = 5'b00101,
        STORE_T     = 5'b01000,
        AMO_T       = 5'b01011,
        ARITH_T     = 5'b01100,
        LUI_T       = 5'b01101,
        BRANCH_T    = 5'b11000,
        JALR_T      = 5'b11001,
        JAL_T       = 5'b11011,
        SYSTEM_T    = 5'b11100
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_RS1_ZERO,
        ALU_RS1_PC,
        ALU_RS1_RF
    } alu_rs1_sel_t;

    typedef enum logic [1:0] {
        ALU_RS2_UPPER_IMM,
        ALU_RS2_ARITH_IMM,
        ALU_RS2_LINK4,
        ALU_RS2_RF
    } alu_rs2_sel_t;

    //////////////////////////////////////////////////
    // Front end and register file
    typedef struct packed {
        addr_t pc;
        logic [31:0] instruction;
    } fetch_packet_t;

    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
    } rf_request_t;

    typedef struct packed {
        data_t rs1_data;
        data_t rs2_data;
        logic rs1_conflict;
        logic rs2_conflict;
        // Producer of a pending rs2
        instr_id_t rs2_id;
    } rf_response_t;

    typedef struct packed {
        opcode_t opcode;
        fn3_t fn3;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        logic uses_rs1;
        logic uses_rs2;
        logic uses_rd;
        logic is_load;
        logic is_store;
        alu_rs1_sel_t alu_rs1_sel;
        alu_rs2_sel_t alu_rs2_sel;
        logic alu_sub;
        unit_vec_t unit_needed;
        logic illegal;
    } decoded_t;

    //////////////////////////////////////////////////
    // Unit payloads
    typedef struct packed {
        // Extra top bit for signed or unsigned compare
        logic [`XLEN:0] in1;
        logic [`XLEN:0] in2;
        logic [4:0] shift_amount;
        logic subtract;
        logic arith;
        logic lshift;
        logic shifter_path;
        logic slt_path;
        logic [1:0] logic_op;
    } alu_inputs_t;

    typedef struct packed {
        data_t rs1;
        data_t rs2;
        addr_t pc;
        fn3_t fn3;
        logic use_signed;
        logic jal;
        logic jalr;
    } branch_inputs_t;

    typedef struct packed {
        data_t rs1;
        data_t rs2;
        logic [11:0] offset;
        fn3_t fn3;
        logic load;
        logic store;
        logic load_store_forward;
        instr_id_t store_forward_id;
    } ls_inputs_t;

    typedef struct packed {
        data_t rs1;
        data_t rs2;
        logic [1:0] op;
        logic reuse_result;
    } div_inputs_t;

endpackage

// ==== verilog/div_reuse_tracker.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module div_reuse_tracker (
    input logic clk,
    input logic rst,
    input decode_pkg::decoded_t decoded,
    input decode_pkg::rf_response_t rf_rsp,
    input decode_pkg::unit_vec_t issue,
    input logic instruction_issued,
    output decode_pkg::div_inputs_t div_inputs
);

    decode_pkg::reg_addr_t prev_div_rs1;
    decode_pkg::reg_addr_t prev_div_rs2;
    logic prev_div_valid;
    logic is_div;
    logic same_sources;
    logic clear_valid;

    assign is_div = decoded.unit_needed[`DIV_UNIT];

    always_ff @(posedge clk) begin
        if (issue[`DIV_UNIT]) begin
            prev_div_rs1 <= decoded.rs1_addr;
            prev_div_rs2 <= decoded.rs2_addr;
        end
    end

    // A divide checks its own sources, anything else the stored ones
    assign clear_valid = decoded.uses_rd
        & ((decoded.rd_addr == (is_div ? decoded.rs1_addr : prev_div_rs1))
        | (decoded.rd_addr == (is_div ? decoded.rs2_addr : prev_div_rs2)));

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_div_valid <= 1'b0;
        end else if (instruction_issued) begin
            prev_div_valid <= (is_div | prev_div_valid) & ~clear_valid;
        end
    end

    assign same_sources = (prev_div_rs1 == decoded.rs1_addr)
                          & (prev_div_rs2 == decoded.rs2_addr);

    assign div_inputs.rs1 = rf_rsp.rs1_data;
    assign div_inputs.rs2 = rf_rsp.rs2_data;
    assign div_inputs.op = decoded.fn3[1:0];
    assign div_inputs.reuse_result = prev_div_valid & same_sources & is_div;

    // Only a legal divide encoding may reuse a result
    reuse_only_for_div: assert property (
        @(posedge clk) disable iff (rst)
            div_inputs.reuse_result |-> (decoded.opcode == decode_pkg::ARITH_T)
                                        && decoded.fn3[2] && !decoded.illegal
    ) else $error("reuse flagged for a non-divide");

endmodule

// ==== verilog/instruction_decoder.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module instruction_decoder (
    input decode_pkg::fetch_packet_t fb,
    output decode_pkg::decoded_t decoded
);

    logic [31:0] instr;
    decode_pkg::opcode_t opcode;
    decode_pkg::fn3_t fn3;
    logic mul_div_op;
    logic slt_fn3;

    assign instr = fb.instruction;
    assign opcode = decode_pkg::opcode_t'(instr[6:2]);
    assign fn3 = instr[14:12];
    assign mul_div_op = instr[25];
    // SLT and SLTU compare by subtraction
    assign slt_fn3 = fn3 inside {3'b010, 3'b011};

    always_comb begin
        decoded = '0;
        decoded.opcode = opcode;
        decoded.fn3 = fn3;
        decoded.rs1_addr = instr[19:15];
        decoded.rs2_addr = instr[24:20];
        decoded.rd_addr = instr[11:7];
        decoded.is_load = (opcode == decode_pkg::LOAD_T);
        decoded.is_store = (opcode == decode_pkg::STORE_T);
        decoded.alu_rs1_sel = decode_pkg::ALU_RS1_RF;
        decoded.alu_rs2_sel = decode_pkg::ALU_RS2_RF;

        case (opcode)
            decode_pkg::LUI_T, decode_pkg::AUIPC_T: begin
                decoded.uses_rd = 1'b1;
                decoded.alu_rs1_sel = (opcode == decode_pkg::LUI_T) ?
                    decode_pkg::ALU_RS1_ZERO : decode_pkg::ALU_RS1_PC;
                decoded.alu_rs2_sel = decode_pkg::ALU_RS2_UPPER_IMM;
                decoded.unit_needed[`ALU_UNIT] = 1'b1;
            end
            decode_pkg::JAL_T, decode_pkg::JALR_T: begin
                decoded.uses_rs1 = (opcode == decode_pkg::JALR_T);
                decoded.uses_rd = 1'b1;
                decoded.alu_rs1_sel = decode_pkg::ALU_RS1_PC;
                decoded.alu_rs2_sel = decode_pkg::ALU_RS2_LINK4;
                decoded.unit_needed[`BRANCH_UNIT] = 1'b1;
            end
            decode_pkg::BRANCH_T: begin
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = 1'b1;
                decoded.unit_needed[`BRANCH_UNIT] = 1'b1;
            end
            decode_pkg::LOAD_T, decode_pkg::STORE_T: begin
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = (opcode == decode_pkg::STORE_T);
                decoded.uses_rd = (opcode == decode_pkg::LOAD_T);
                decoded.unit_needed[`LS_UNIT] = 1'b1;
            end
            decode_pkg::ARITH_IMM_T: begin
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rd = 1'b1;
                decoded.alu_rs2_sel = decode_pkg::ALU_RS2_ARITH_IMM;
                decoded.alu_sub = slt_fn3;
                decoded.unit_needed[`ALU_UNIT] = 1'b1;
            end
            decode_pkg::ARITH_T: begin
                decoded.uses_rs1 = 1'b1;
                decoded.uses_rs2 = 1'b1;
                decoded.uses_rd = 1'b1;
                decoded.alu_sub = ((fn3 == 3'b000) & instr[30]) | slt_fn3;
                // Only the divide half of the M extension exists
                if (!mul_div_op)
                    decoded.unit_needed[`ALU_UNIT] = 1'b1;
                else if (fn3[2])
                    decoded.unit_needed[`DIV_UNIT] = 1'b1;
                else
                    decoded.illegal = 1'b1;
            end
            // No control unit and no atomics in this core
            decode_pkg::FENCE_T, decode_pkg::SYSTEM_T, decode_pkg::AMO_T:
                decoded.illegal = 1'b1;
            default:
                decoded.illegal = 1'b1;
        endcase
    end

endmodule

// ==== verilog/issue_control.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module issue_control (
    input logic clk,
    input logic rst,
    input logic fb_valid,
    input decode_pkg::decoded_t decoded,
    input decode_pkg::rf_response_t rf_rsp,
    input logic forward_ok,
    input logic id_available,
    input logic issue_hold,
    input decode_pkg::unit_vec_t unit_ready,
    output decode_pkg::unit_vec_t unit_issue,
    output logic instruction_issued,
    output logic fb_pop,
    output logic illegal_instruction
);

    logic issue_valid;
    logic rs1_ready;
    logic rs2_ready;
    logic ls_rs2_ready;
    decode_pkg::unit_vec_t unit_operands_ready;

    //////////////////////////////////////////////////
    // Issue conditions
    assign issue_valid = fb_valid & id_available & ~issue_hold & ~decoded.illegal;

    // Unused source fields never stall
    assign rs1_ready = ~(decoded.uses_rs1 & rf_rsp.rs1_conflict);
    assign rs2_ready = ~(decoded.uses_rs2 & rf_rsp.rs2_conflict);

    // Store data may still be in flight from a load
    assign ls_rs2_ready = rs2_ready | (decoded.is_store & forward_ok);

    always_comb begin
        unit_operands_ready = {`NUM_UNITS{rs1_ready & rs2_ready}};
        unit_operands_ready[`LS_UNIT] = rs1_ready & ls_rs2_ready;
    end

    //////////////////////////////////////////////////
    // Strobes
    assign unit_issue = {`NUM_UNITS{issue_valid}} & unit_operands_ready
                        & decoded.unit_needed & unit_ready;

    assign instruction_issued = |unit_issue;
    assign fb_pop = instruction_issued;

    assign illegal_instruction = fb_valid & decoded.illegal;

    //////////////////////////////////////////////////
    // Assertions

    // Decoder selects at most one unit
    unit_issue_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(unit_issue)
    ) else $error("more than one unit issued");

    pop_needs_valid: assert property (
        @(posedge clk) disable iff (rst) fb_pop |-> fb_valid
    ) else $error("fetch buffer popped while empty");

endmodule

// ==== verilog/load_store_tracker.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module load_store_tracker (
    input logic clk,
    input logic rst,
    input decode_pkg::fetch_packet_t fb,
    input decode_pkg::decoded_t decoded,
    input decode_pkg::rf_response_t rf_rsp,
    input decode_pkg::unit_vec_t issue,
    input logic instruction_issued,
    output logic forward_ok,
    output decode_pkg::ls_inputs_t ls_inputs
);

    // One bit per register, last issued writer was a load
    logic [`NUM_REGS-1:0] last_use_was_load;
    decode_pkg::reg_addr_t last_ls_rd;
    logic [11:0] ls_offset;

    //////////////////////////////////////////////////
    // Forwarding table
    always_ff @(posedge clk) begin
        if (rst) begin
            last_use_was_load <= '0;
        end else if (instruction_issued) begin
            last_use_was_load[decoded.rd_addr] <= issue[`LS_UNIT] & decoded.is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (issue[`LS_UNIT]) begin
            last_ls_rd <= decoded.rd_addr;
        end
    end

    // Store data comes straight from the most recent load
    assign forward_ok = last_use_was_load[decoded.rs2_addr]
                        & (last_ls_rd == decoded.rs2_addr);

    //////////////////////////////////////////////////
    // Payload

    // S-type splits the offset around rd
    assign ls_offset = decoded.is_store ? {fb.instruction[31:25], fb.instruction[11:7]}
                                        : fb.instruction[31:20];

    assign ls_inputs.rs1 = rf_rsp.rs1_data;
    assign ls_inputs.rs2 = rf_rsp.rs2_data;
    assign ls_inputs.offset = ls_offset;
    assign ls_inputs.fn3 = decoded.fn3;
    assign ls_inputs.load = decoded.is_load;
    assign ls_inputs.store = decoded.is_store;
    assign ls_inputs.load_store_forward = rf_rsp.rs2_conflict & forward_ok;
    assign ls_inputs.store_forward_id = rf_rsp.rs2_id;

endmodule
